// File: glb_consts.svh
// Global buffer configuration constants for address fields, widths and sizes
`ifndef GLB_CONSTS_SVH
`define GLB_CONSTS_SVH

// Chain and queue sizes
`define GLB_NUM_TILES 4
`define GLB_QUEUE_DEPTH 2

// Address split, tile field on top of register field
`define GLB_TILE_SEL_W 2
`define GLB_REG_ADDR_W 4
`define GLB_CFG_ADDR_W (`GLB_TILE_SEL_W + `GLB_REG_ADDR_W)
`define GLB_DATA_W 32

// DMA header fields
`define GLB_ADDR_W 22
`define GLB_WORDS_W 21
`define GLB_STRIDE_W 11
`define GLB_LATENCY_W 5

// Register spacing between consecutive store and load headers
`define GLB_ST_REG_STEP 3
`define GLB_LD_REG_STEP 4

`endif

// File: glb_pkg.sv
// Global buffer configuration types for DMA headers, register map and controller
`default_nettype none
`include "glb_consts.svh"

package glb_pkg;

    typedef struct packed {
        logic                    valid;
        logic [`GLB_ADDR_W-1:0]  start_addr;
        logic [`GLB_WORDS_W-1:0] num_words;
    } dma_st_header_t;

    typedef struct packed {
        logic                     valid;
        logic [`GLB_ADDR_W-1:0]   start_addr;
        logic [`GLB_WORDS_W-1:0]  num_words;
        logic [`GLB_STRIDE_W-1:0] stride;
    } dma_ld_header_t;

    // Register numbers of header 0, header q sits at base + step * q
    typedef enum logic [`GLB_REG_ADDR_W-1:0] {
        REG_TILE_CTRL   = 0,
        REG_LATENCY     = 1,
        REG_ST_VALIDATE = 2,
        REG_ST_START    = 3,
        REG_ST_WORDS    = 4,
        REG_LD_VALIDATE = 8,
        REG_LD_START    = 9,
        REG_LD_WORDS    = 10,
        REG_LD_STRIDE   = 11
    } cfg_reg_e;

    typedef enum logic {
        CFG_OP_READ  = 1'b0,
        CFG_OP_WRITE = 1'b1
    } cfg_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_LOCAL = 2'd1,
        ST_FWD   = 2'd2,
        ST_DONE  = 2'd3
    } cfg_state_e;

endpackage

`default_nettype wire

// File: cfg_ifc.sv
// Configuration interface with four-phase req/ack handshake between tiles
`timescale 1ns/100ps
`default_nettype none
`include "glb_consts.svh"

interface cfg_ifc;

    logic                       req;
    logic                       wr;
    logic [`GLB_CFG_ADDR_W-1:0] addr;
    logic [`GLB_DATA_W-1:0]     wr_data;
    logic                       ack;
    logic [`GLB_DATA_W-1:0]     rd_data;
    logic                       nack;

    // rd_data and nack only meaningful while ack is high
    modport master (
        output req, wr, addr, wr_data,
        input  ack, rd_data, nack
    );

    modport slave (
        input  req, wr, addr, wr_data,
        output ack, rd_data, nack
    );

endinterface

`default_nettype wire

// File: glb_tile_cfg_ctrl.sv
// Tile configuration controller that serves local requests or forwards them east
`timescale 1ns/100ps
`default_nettype none
`include "glb_consts.svh"

module glb_tile_cfg_ctrl #(
    parameter int TILE_ID = 0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    cfg_ifc.slave                      if_cfg_wst_s,
    cfg_ifc.master                     if_cfg_est_m,
    input  logic [`GLB_DATA_W-1:0]     pio_rd_data,
    input  logic                       pio_nack,
    output logic                       pio_read,
    output logic                       pio_write,
    output logic [`GLB_REG_ADDR_W-1:0] pio_addr,
    output logic [`GLB_DATA_W-1:0]     pio_wr_data
);

    localparam logic [`GLB_TILE_SEL_W-1:0] MY_TILE = `GLB_TILE_SEL_W'(TILE_ID);

    glb_pkg::cfg_state_e state;
    glb_pkg::cfg_op_e    op;
    logic                tile_hit;
    logic                start;
    logic                pio_busy;

    assign op       = glb_pkg::cfg_op_e'(if_cfg_wst_s.wr);
    assign tile_hit = if_cfg_wst_s.addr[`GLB_CFG_ADDR_W-1 -: `GLB_TILE_SEL_W] == MY_TILE;
    assign start    = (state == glb_pkg::ST_IDLE) && if_cfg_wst_s.req;
    assign pio_busy = pio_read || pio_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state            <= glb_pkg::ST_IDLE;
            pio_read         <= 1'b0;
            pio_write        <= 1'b0;
            if_cfg_wst_s.ack <= 1'b0;
            if_cfg_wst_s.nack <= 1'b0;
            if_cfg_est_m.req <= 1'b0;
        end else begin
            case (state)
                glb_pkg::ST_IDLE: begin
                    if (if_cfg_wst_s.req && tile_hit) begin
                        pio_read  <= (op == glb_pkg::CFG_OP_READ);
                        pio_write <= (op == glb_pkg::CFG_OP_WRITE);
                        state     <= glb_pkg::ST_LOCAL;
                    end else if (if_cfg_wst_s.req) begin
                        if_cfg_est_m.req <= 1'b1;
                        state            <= glb_pkg::ST_FWD;
                    end
                end
                glb_pkg::ST_LOCAL: begin
                    pio_read  <= 1'b0;
                    pio_write <= 1'b0;
                    // Strobe cycle first, register file answers in the next one
                    if (!pio_busy) begin
                        if_cfg_wst_s.ack  <= 1'b1;
                        if_cfg_wst_s.nack <= pio_nack;
                        state             <= glb_pkg::ST_DONE;
                    end
                end
                glb_pkg::ST_FWD: begin
                    if (if_cfg_est_m.ack) begin
                        if_cfg_wst_s.ack  <= 1'b1;
                        if_cfg_wst_s.nack <= if_cfg_est_m.nack;
                        state             <= glb_pkg::ST_DONE;
                    end
                end
                glb_pkg::ST_DONE: begin
                    // Release east first, west ack follows once east ack is gone
                    if (!if_cfg_wst_s.req) begin
                        if_cfg_est_m.req <= 1'b0;
                        if (!if_cfg_est_m.req && !if_cfg_est_m.ack) begin
                            if_cfg_wst_s.ack <= 1'b0;
                            state            <= glb_pkg::ST_IDLE;
                        end
                    end
                end
                default: state <= glb_pkg::ST_IDLE;
            endcase
        end
    end

    // Request fields and returned data
    always_ff @(posedge clk) begin
        if (start) begin
            pio_addr             <= if_cfg_wst_s.addr[`GLB_REG_ADDR_W-1:0];
            pio_wr_data          <= if_cfg_wst_s.wr_data;
            if_cfg_est_m.wr      <= if_cfg_wst_s.wr;
            if_cfg_est_m.addr    <= if_cfg_wst_s.addr;
            if_cfg_est_m.wr_data <= if_cfg_wst_s.wr_data;
        end
        if (state == glb_pkg::ST_LOCAL && !pio_busy) begin
            if_cfg_wst_s.rd_data <= pio_rd_data;
        end else if (state == glb_pkg::ST_FWD && if_cfg_est_m.ack) begin
            if_cfg_wst_s.rd_data <= if_cfg_est_m.rd_data;
        end
    end

endmodule

`default_nettype wire

// File: glb_pio.sv
// Tile register file with address decode, read mux and DMA valid clearing
`timescale 1ns/100ps
`default_nettype none
`include "glb_consts.svh"

module glb_pio (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pio_read,
    input  logic                       pio_write,
    input  logic [`GLB_REG_ADDR_W-1:0] pio_addr,
    input  logic [`GLB_DATA_W-1:0]     pio_wr_data,
    input  logic                       st_invalidate_pulse [`GLB_QUEUE_DEPTH],
    input  logic                       ld_invalidate_pulse [`GLB_QUEUE_DEPTH],
    output logic [`GLB_DATA_W-1:0]     pio_rd_data,
    output logic                       pio_nack,
    output logic [1:0]                 strm_g2f_mux,
    output logic [1:0]                 strm_f2g_mux,
    output logic [1:0]                 ld_dma_mode,
    output logic [1:0]                 st_dma_mode,
    output logic [`GLB_LATENCY_W-1:0]  latency,
    output logic                       st_valid [`GLB_QUEUE_DEPTH],
    output logic [`GLB_ADDR_W-1:0]     st_start_addr [`GLB_QUEUE_DEPTH],
    output logic [`GLB_WORDS_W-1:0]    st_num_words [`GLB_QUEUE_DEPTH],
    output logic                       ld_valid [`GLB_QUEUE_DEPTH],
    output logic [`GLB_ADDR_W-1:0]     ld_start_addr [`GLB_QUEUE_DEPTH],
    output logic [`GLB_WORDS_W-1:0]    ld_num_words [`GLB_QUEUE_DEPTH],
    output logic [`GLB_STRIDE_W-1:0]   ld_stride [`GLB_QUEUE_DEPTH]
);

    localparam int QD = `GLB_QUEUE_DEPTH;

    logic                   sel_ctrl;
    logic                   sel_latency;
    logic [QD-1:0]          sel_st_valid;
    logic [QD-1:0]          sel_st_start;
    logic [QD-1:0]          sel_st_words;
    logic [QD-1:0]          sel_ld_valid;
    logic [QD-1:0]          sel_ld_start;
    logic [QD-1:0]          sel_ld_words;
    logic [QD-1:0]          sel_ld_stride;
    logic                   mapped;
    logic [`GLB_DATA_W-1:0] rd_mux;

    // Decode, header q lives at its base register plus step * q
    always_comb begin
        sel_ctrl    = (pio_addr == glb_pkg::REG_TILE_CTRL);
        sel_latency = (pio_addr == glb_pkg::REG_LATENCY);
        for (int q = 0; q < QD; q++) begin
            sel_st_valid[q]  = (pio_addr == glb_pkg::REG_ST_VALIDATE + `GLB_ST_REG_STEP * q);
            sel_st_start[q]  = (pio_addr == glb_pkg::REG_ST_START + `GLB_ST_REG_STEP * q);
            sel_st_words[q]  = (pio_addr == glb_pkg::REG_ST_WORDS + `GLB_ST_REG_STEP * q);
            sel_ld_valid[q]  = (pio_addr == glb_pkg::REG_LD_VALIDATE + `GLB_LD_REG_STEP * q);
            sel_ld_start[q]  = (pio_addr == glb_pkg::REG_LD_START + `GLB_LD_REG_STEP * q);
            sel_ld_words[q]  = (pio_addr == glb_pkg::REG_LD_WORDS + `GLB_LD_REG_STEP * q);
            sel_ld_stride[q] = (pio_addr == glb_pkg::REG_LD_STRIDE + `GLB_LD_REG_STEP * q);
        end
        mapped = sel_ctrl || sel_latency || (|sel_st_valid) || (|sel_st_start)
            || (|sel_st_words) || (|sel_ld_valid) || (|sel_ld_start)
            || (|sel_ld_words) || (|sel_ld_stride);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            strm_g2f_mux <= '0;
            strm_f2g_mux <= '0;
            ld_dma_mode  <= '0;
            st_dma_mode  <= '0;
            latency      <= '0;
            for (int q = 0; q < QD; q++) begin
                st_valid[q]      <= 1'b0;
                st_start_addr[q] <= '0;
                st_num_words[q]  <= '0;
                ld_valid[q]      <= 1'b0;
                ld_start_addr[q] <= '0;
                ld_num_words[q]  <= '0;
                ld_stride[q]     <= '0;
            end
        end else begin
            if (pio_write && sel_ctrl) begin
                strm_g2f_mux <= pio_wr_data[1:0];
                strm_f2g_mux <= pio_wr_data[3:2];
                ld_dma_mode  <= pio_wr_data[5:4];
                st_dma_mode  <= pio_wr_data[7:6];
            end
            if (pio_write && sel_latency) latency <= pio_wr_data[`GLB_LATENCY_W-1:0];
            for (int q = 0; q < QD; q++) begin
                // Host write beats a same-cycle invalidate
                if (pio_write && sel_st_valid[q]) st_valid[q] <= pio_wr_data[0];
                else if (st_invalidate_pulse[q]) st_valid[q] <= 1'b0;
                if (pio_write && sel_ld_valid[q]) ld_valid[q] <= pio_wr_data[0];
                else if (ld_invalidate_pulse[q]) ld_valid[q] <= 1'b0;
                if (pio_write && sel_st_start[q]) begin
                    st_start_addr[q] <= pio_wr_data[`GLB_ADDR_W-1:0];
                end
                if (pio_write && sel_st_words[q]) begin
                    st_num_words[q] <= pio_wr_data[`GLB_WORDS_W-1:0];
                end
                if (pio_write && sel_ld_start[q]) begin
                    ld_start_addr[q] <= pio_wr_data[`GLB_ADDR_W-1:0];
                end
                if (pio_write && sel_ld_words[q]) begin
                    ld_num_words[q] <= pio_wr_data[`GLB_WORDS_W-1:0];
                end
                if (pio_write && sel_ld_stride[q]) ld_stride[q] <= pio_wr_data[`GLB_STRIDE_W-1:0];
            end
        end
    end

    // Zero-extended read data, unmapped numbers read as 0
    always_comb begin
        rd_mux = '0;
        if (sel_ctrl) begin
            rd_mux = `GLB_DATA_W'({st_dma_mode, ld_dma_mode, strm_f2g_mux, strm_g2f_mux});
        end
        if (sel_latency) rd_mux = `GLB_DATA_W'(latency);
        for (int q = 0; q < QD; q++) begin
            if (sel_st_valid[q]) rd_mux = `GLB_DATA_W'(st_valid[q]);
            if (sel_st_start[q]) rd_mux = `GLB_DATA_W'(st_start_addr[q]);
            if (sel_st_words[q]) rd_mux = `GLB_DATA_W'(st_num_words[q]);
            if (sel_ld_valid[q]) rd_mux = `GLB_DATA_W'(ld_valid[q]);
            if (sel_ld_start[q]) rd_mux = `GLB_DATA_W'(ld_start_addr[q]);
            if (sel_ld_words[q]) rd_mux = `GLB_DATA_W'(ld_num_words[q]);
            if (sel_ld_stride[q]) rd_mux = `GLB_DATA_W'(ld_stride[q]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pio_nack <= 1'b0;
        end else if (pio_read || pio_write) begin
            pio_nack <= !mapped;
        end
    end

    // Writes return zero data
    always_ff @(posedge clk) begin
        if (pio_read) pio_rd_data <= rd_mux;
        else if (pio_write) pio_rd_data <= '0;
    end

endmodule

`default_nettype wire

// File: glb_tile_cfg.sv
// Tile configuration block, controller plus register file with header outputs
`timescale 1ns/100ps
`default_nettype none
`include "glb_consts.svh"

module glb_tile_cfg #(
    parameter int TILE_ID = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    cfg_ifc.slave                     if_cfg_wst_s,
    cfg_ifc.master                    if_cfg_est_m,
    input  logic                      st_invalidate_pulse [`GLB_QUEUE_DEPTH],
    input  logic                      ld_invalidate_pulse [`GLB_QUEUE_DEPTH],
    output logic [1:0]                cfg_strm_g2f_mux,
    output logic [1:0]                cfg_strm_f2g_mux,
    output logic [1:0]                cfg_ld_dma_mode,
    output logic [1:0]                cfg_st_dma_mode,
    output logic [`GLB_LATENCY_W-1:0] cfg_latency,
    output glb_pkg::dma_st_header_t   cfg_st_dma_header [`GLB_QUEUE_DEPTH],
    output glb_pkg::dma_ld_header_t   cfg_ld_dma_header [`GLB_QUEUE_DEPTH]
);

    logic                       pio_read;
    logic                       pio_write;
    logic [`GLB_REG_ADDR_W-1:0] pio_addr;
    logic [`GLB_DATA_W-1:0]     pio_wr_data;
    logic [`GLB_DATA_W-1:0]     pio_rd_data;
    logic                       pio_nack;

    logic                       st_valid [`GLB_QUEUE_DEPTH];
    logic [`GLB_ADDR_W-1:0]     st_start_addr [`GLB_QUEUE_DEPTH];
    logic [`GLB_WORDS_W-1:0]    st_num_words [`GLB_QUEUE_DEPTH];
    logic                       ld_valid [`GLB_QUEUE_DEPTH];
    logic [`GLB_ADDR_W-1:0]     ld_start_addr [`GLB_QUEUE_DEPTH];
    logic [`GLB_WORDS_W-1:0]    ld_num_words [`GLB_QUEUE_DEPTH];
    logic [`GLB_STRIDE_W-1:0]   ld_stride [`GLB_QUEUE_DEPTH];

    glb_tile_cfg_ctrl #(
        .TILE_ID(TILE_ID)
    ) u_ctrl (
        .clk, .rst_n, .if_cfg_wst_s, .if_cfg_est_m,
        .pio_rd_data, .pio_nack, .pio_read, .pio_write, .pio_addr, .pio_wr_data
    );

    glb_pio u_pio (
        .clk, .rst_n, .pio_read, .pio_write, .pio_addr, .pio_wr_data,
        .st_invalidate_pulse, .ld_invalidate_pulse, .pio_rd_data, .pio_nack,
        .strm_g2f_mux (cfg_strm_g2f_mux),
        .strm_f2g_mux (cfg_strm_f2g_mux),
        .ld_dma_mode  (cfg_ld_dma_mode),
        .st_dma_mode  (cfg_st_dma_mode),
        .latency      (cfg_latency),
        .st_valid, .st_start_addr, .st_num_words,
        .ld_valid, .ld_start_addr, .ld_num_words, .ld_stride
    );

    // Header structs for the DMA engines
    always_comb begin
        for (int q = 0; q < `GLB_QUEUE_DEPTH; q++) begin
            cfg_st_dma_header[q].valid      = st_valid[q];
            cfg_st_dma_header[q].start_addr = st_start_addr[q];
            cfg_st_dma_header[q].num_words  = st_num_words[q];
            cfg_ld_dma_header[q].valid      = ld_valid[q];
            cfg_ld_dma_header[q].start_addr = ld_start_addr[q];
            cfg_ld_dma_header[q].num_words  = ld_num_words[q];
            cfg_ld_dma_header[q].stride     = ld_stride[q];
        end
    end

endmodule

`default_nettype wire

// File: glb_cfg_top.sv
// Global buffer configuration top, a west-to-east chain of tile config blocks
`timescale 1ns/100ps
`default_nettype none
`include "glb_consts.svh"

module glb_cfg_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_req,
    input  logic                       cfg_wr,
    input  logic [`GLB_CFG_ADDR_W-1:0] cfg_addr,
    input  logic [`GLB_DATA_W-1:0]     cfg_wr_data,
    input  logic                       st_invalidate_pulse [`GLB_NUM_TILES][`GLB_QUEUE_DEPTH],
    input  logic                       ld_invalidate_pulse [`GLB_NUM_TILES][`GLB_QUEUE_DEPTH],
    output logic                       cfg_ack,
    output logic [`GLB_DATA_W-1:0]     cfg_rd_data,
    output logic                       cfg_nack,
    output glb_pkg::dma_st_header_t    st_dma_header [`GLB_NUM_TILES][`GLB_QUEUE_DEPTH],
    output glb_pkg::dma_ld_header_t    ld_dma_header [`GLB_NUM_TILES][`GLB_QUEUE_DEPTH],
    // Whole tile control image per tile, stream muxes in bits 3:0
    output logic [7:0]                 tile_ctrl_strm_mux [`GLB_NUM_TILES],
    output logic [`GLB_LATENCY_W-1:0]  latency [`GLB_NUM_TILES]
);

    // Link t feeds tile t from the west
    cfg_ifc if_cfg [`GLB_NUM_TILES+1] ();

    assign if_cfg[0].req     = cfg_req;
    assign if_cfg[0].wr      = cfg_wr;
    assign if_cfg[0].addr    = cfg_addr;
    assign if_cfg[0].wr_data = cfg_wr_data;
    assign cfg_ack           = if_cfg[0].ack;
    assign cfg_rd_data       = if_cfg[0].rd_data;
    assign cfg_nack          = if_cfg[0].nack;

    // Every tile number exists, so the last east port never sees a request
    assign if_cfg[`GLB_NUM_TILES].ack     = 1'b0;
    assign if_cfg[`GLB_NUM_TILES].rd_data = '0;
    assign if_cfg[`GLB_NUM_TILES].nack    = 1'b0;

    for (genvar t = 0; t < `GLB_NUM_TILES; t++) begin : g_tile
        logic [1:0] g2f_mux;
        logic [1:0] f2g_mux;
        logic [1:0] ld_mode;
        logic [1:0] st_mode;

        glb_tile_cfg #(
            .TILE_ID(t)
        ) u_tile_cfg (
            .clk, .rst_n,
            .if_cfg_wst_s        (if_cfg[t]),
            .if_cfg_est_m        (if_cfg[t+1]),
            .st_invalidate_pulse (st_invalidate_pulse[t]),
            .ld_invalidate_pulse (ld_invalidate_pulse[t]),
            .cfg_strm_g2f_mux    (g2f_mux),
            .cfg_strm_f2g_mux    (f2g_mux),
            .cfg_ld_dma_mode     (ld_mode),
            .cfg_st_dma_mode     (st_mode),
            .cfg_latency         (latency[t]),
            .cfg_st_dma_header   (st_dma_header[t]),
            .cfg_ld_dma_header   (ld_dma_header[t])
        );

        assign tile_ctrl_strm_mux[t] = {st_mode, ld_mode, f2g_mux, g2f_mux};
    end

endmodule

`default_nettype wire

// File: glb_cfg_props.sv
// Handshake properties for the tile configuration controller, bound from the testbench
`timescale 1ns/100ps
`default_nettype none

module glb_cfg_props (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic req,
    input wire logic ack,
    input wire logic est_req,
    input wire logic est_ack,
    input wire logic pio_read,
    input wire logic pio_write
);

    // Ack only rises on a pending west request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("west ack rose without a west request");

    req_holds_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        req && !ack |=> req)
        else $error("west request dropped before ack");

    est_req_holds_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        est_req && !est_ack |=> est_req)
        else $error("east request dropped before east ack");

    // Ack is released only once the request is gone
    ack_holds_while_req: assert property (@(posedge clk) disable iff (!rst_n)
        ack && req |=> ack)
        else $error("west ack dropped while request still high");

    single_pio_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(pio_read && pio_write))
        else $error("register file read and write strobes high together");

endmodule

`default_nettype wire

// File: glb_cfg_tb.sv
// Self-checking testbench for the global buffer configuration chain
`timescale 1ns/100ps
`default_nettype none
`include "glb_consts.svh"

module glb_cfg_tb;

    localparam int NT = `GLB_NUM_TILES;
    localparam int QD = `GLB_QUEUE_DEPTH;

    logic                       clk;
    logic                       rst_n;
    logic                       cfg_req;
    logic                       cfg_wr;
    logic [`GLB_CFG_ADDR_W-1:0] cfg_addr;
    logic [`GLB_DATA_W-1:0]     cfg_wr_data;
    logic                       st_inv [NT][QD];
    logic                       ld_inv [NT][QD];
    logic                       cfg_ack;
    logic [`GLB_DATA_W-1:0]     cfg_rd_data;
    logic                       cfg_nack;
    glb_pkg::dma_st_header_t    st_hdr [NT][QD];
    glb_pkg::dma_ld_header_t    ld_hdr [NT][QD];
    logic [7:0]                 tile_ctrl [NT];
    logic [`GLB_LATENCY_W-1:0]  tile_latency [NT];

    // Expected register contents
    logic [7:0]                m_ctrl [NT];
    logic [`GLB_LATENCY_W-1:0] m_lat [NT];
    logic                      m_st_valid [NT][QD];
    logic [`GLB_ADDR_W-1:0]    m_st_start [NT][QD];
    logic [`GLB_WORDS_W-1:0]   m_st_words [NT][QD];
    logic                      m_ld_valid [NT][QD];
    logic [`GLB_ADDR_W-1:0]    m_ld_start [NT][QD];
    logic [`GLB_WORDS_W-1:0]   m_ld_words [NT][QD];
    logic [`GLB_STRIDE_W-1:0]  m_ld_stride [NT][QD];

    string                      ops [$];
    logic [`GLB_CFG_ADDR_W-1:0] addrs [$];
    logic [`GLB_DATA_W-1:0]     datas [$];
    logic [`GLB_DATA_W-1:0]     exp_data [$];
    logic                       exp_nack [$];

    int value_errors = 0;
    int other_errors = 0;
    int cycles = 0;
    int limit = 0;
    int tile;
    int reg_num;
    logic [`GLB_DATA_W-1:0] rd;
    logic                   nack;

    glb_cfg_top glb_cfg_top_inst (
        .clk, .rst_n, .cfg_req, .cfg_wr, .cfg_addr, .cfg_wr_data,
        .st_invalidate_pulse (st_inv),
        .ld_invalidate_pulse (ld_inv),
        .cfg_ack, .cfg_rd_data, .cfg_nack,
        .st_dma_header       (st_hdr),
        .ld_dma_header       (ld_hdr),
        .tile_ctrl_strm_mux  (tile_ctrl),
        .latency             (tile_latency)
    );

    bind glb_tile_cfg_ctrl glb_cfg_props u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (if_cfg_wst_s.req),
        .ack       (if_cfg_wst_s.ack),
        .est_req   (if_cfg_est_m.req),
        .est_ack   (if_cfg_est_m.ack),
        .pio_read  (pio_read),
        .pio_write (pio_write)
    );

    always #50 clk = ~clk;

    task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task load_input(output bit ok);
        int    fd;
        int    n;
        string line;
        string op_s;
        logic [`GLB_DATA_W-1:0] a;
        logic [`GLB_DATA_W-1:0] d;
        logic [`GLB_DATA_W-1:0] e;
        logic [`GLB_DATA_W-1:0] k;
        ok = 0;
        fd = $fopen("glb_cfg_input.txt", "r");
        if (fd != 0) begin
            ok = 1;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h", op_s, a, d, e, k);
                    if (n == 5) begin
                        ops.push_back(op_s);
                        addrs.push_back(a[`GLB_CFG_ADDR_W-1:0]);
                        datas.push_back(d);
                        exp_data.push_back(e);
                        exp_nack.push_back(k[0]);
                    end else begin
                        other_errors++;
                        $display("Input line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Four-phase transfer on the west port of tile 0, started on the current edge
    task run_cfg(input logic wr, input logic [`GLB_CFG_ADDR_W-1:0] addr,
                 input logic [`GLB_DATA_W-1:0] data);
        cfg_req     <= 1'b1;
        cfg_wr      <= wr;
        cfg_addr    <= addr;
        cfg_wr_data <= data;
        @(posedge clk);
        while (!cfg_ack) @(posedge clk);
        rd = cfg_rd_data;
        nack = cfg_nack;
        cfg_req <= 1'b0;
        @(posedge clk);
        while (cfg_ack) @(posedge clk);
    endtask

    // Register map: store q at 2+3q.., load q at 8+4q.., fields truncated
    task model_write(input int t, input int r, input logic [`GLB_DATA_W-1:0] d);
        int q;
        int k;
        if (r == 0) begin
            m_ctrl[t] = d[7:0];
        end else if (r == 1) begin
            m_lat[t] = d[`GLB_LATENCY_W-1:0];
        end else if (r < 8) begin
            q = (r - 2) / 3;
            k = (r - 2) % 3;
            if (q < QD) begin
                case (k)
                    0: m_st_valid[t][q] = d[0];
                    1: m_st_start[t][q] = d[`GLB_ADDR_W-1:0];
                    default: m_st_words[t][q] = d[`GLB_WORDS_W-1:0];
                endcase
            end
        end else begin
            q = (r - 8) / 4;
            k = (r - 8) % 4;
            if (q < QD) begin
                case (k)
                    0: m_ld_valid[t][q] = d[0];
                    1: m_ld_start[t][q] = d[`GLB_ADDR_W-1:0];
                    2: m_ld_words[t][q] = d[`GLB_WORDS_W-1:0];
                    default: m_ld_stride[t][q] = d[`GLB_STRIDE_W-1:0];
                endcase
            end
        end
    endtask

    // One-cycle pulse on the header named by its validate register
    task pulse_invalidate(input int t, input int r);
        int q;
        if (r >= 2 && r < 8 && (r - 2) % 3 == 0 && (r - 2) / 3 < QD) begin
            q = (r - 2) / 3;
            @(posedge clk);
            st_inv[t][q] <= 1'b1;
            @(posedge clk);
            st_inv[t][q] <= 1'b0;
            m_st_valid[t][q] = 1'b0;
        end else if (r >= 8 && (r - 8) % 4 == 0 && (r - 8) / 4 < QD) begin
            q = (r - 8) / 4;
            @(posedge clk);
            ld_inv[t][q] <= 1'b1;
            @(posedge clk);
            ld_inv[t][q] <= 1'b0;
            m_ld_valid[t][q] = 1'b0;
        end else begin
            other_errors++;
            $display("Invalidate line does not name a validate register");
        end
        @(posedge clk);
    endtask

    task check_ports;
        for (int t = 0; t < NT; t++) begin
            check_value($sformatf("tile_ctrl_strm_mux[%0d]", t), tile_ctrl[t], m_ctrl[t]);
            check_value($sformatf("latency[%0d]", t), tile_latency[t], m_lat[t]);
            for (int q = 0; q < QD; q++) begin
                check_value($sformatf("st_dma_header[%0d][%0d]", t, q), st_hdr[t][q],
                    {m_st_valid[t][q], m_st_start[t][q], m_st_words[t][q]});
                check_value($sformatf("ld_dma_header[%0d][%0d]", t, q), ld_hdr[t][q],
                    {m_ld_valid[t][q], m_ld_start[t][q], m_ld_words[t][q],
                     m_ld_stride[t][q]});
            end
        end
    endtask

    // Limit grows with the number of input lines
    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        bit ok;
        clk         = 1'b0;
        rst_n       = 1'b0;
        cfg_req     = 1'b0;
        cfg_wr      = 1'b0;
        cfg_addr    = '0;
        cfg_wr_data = '0;
        for (int t = 0; t < NT; t++) begin
            m_ctrl[t] = '0;
            m_lat[t]  = '0;
            for (int q = 0; q < QD; q++) begin
                st_inv[t][q]      = 1'b0;
                ld_inv[t][q]      = 1'b0;
                m_st_valid[t][q]  = 1'b0;
                m_st_start[t][q]  = '0;
                m_st_words[t][q]  = '0;
                m_ld_valid[t][q]  = 1'b0;
                m_ld_start[t][q]  = '0;
                m_ld_words[t][q]  = '0;
                m_ld_stride[t][q] = '0;
            end
        end
        void'($urandom(26994));
        load_input(ok);
        if (!ok) begin
            other_errors++;
            $display("Input file glb_cfg_input.txt could not be opened");
        end else begin
            limit = 64 * ops.size() + 100;
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            @(posedge clk);
            check_value("cfg_ack", cfg_ack, 0);
            check_ports();
            for (int i = 0; i < ops.size(); i++) begin
                // Idle gap of zero keeps transactions back to back
                repeat ($urandom % 4) @(posedge clk);
                tile    = addrs[i][`GLB_CFG_ADDR_W-1 -: `GLB_TILE_SEL_W];
                reg_num = addrs[i][`GLB_REG_ADDR_W-1:0];
                case (ops[i])
                    "W": begin
                        run_cfg(1'b1, addrs[i], datas[i]);
                        model_write(tile, reg_num, datas[i]);
                        check_value("cfg_nack", nack, exp_nack[i]);
                    end
                    "R": begin
                        run_cfg(1'b0, addrs[i], '0);
                        check_value("cfg_rd_data", rd, exp_data[i]);
                        check_value("cfg_nack", nack, exp_nack[i]);
                    end
                    "I": pulse_invalidate(tile, reg_num);
                    default: begin
                        other_errors++;
                        $display("Unknown operation %s on input line %0d", ops[i], i);
                    end
                endcase
                check_ports();
            end
        end
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
glb_pkg.sv
cfg_ifc.sv
glb_tile_cfg_ctrl.sv
glb_pio.sv
glb_tile_cfg.sv
glb_cfg_top.sv
glb_cfg_props.sv
glb_cfg_tb.sv

// File: glb_cfg_input.txt
# Columns: op (W write, R read, I invalidate), address {tile, reg}, data,
# expected read data, expected nack; numbers in hex, data unused on I lines
W 00 ffffffa7 0 0
R 00 0 000000a7 0
W 01 ffffffff 0 0
R 01 0 0000001f 0
W 12 00000001 0 0
W 13 ffffffff 0 0
W 14 ffffffff 0 0
R 13 0 003fffff 0
R 14 0 001fffff 0
W 25 00000003 0 0
W 26 12345678 0 0
R 25 0 00000001 0
R 26 0 00345678 0
W 3c 00000001 0 0
W 3d aaaaaaaa 0 0
W 3e 55555555 0 0
W 3f 0000ffff 0 0
R 3e 0 00155555 0
R 3f 0 000007ff 0
W 08 00000001 0 0
W 0b 00000123 0 0
R 0b 0 00000123 0
R 10 0 00000000 0
R 33 0 00000000 0
I 12 0 0 0
R 12 0 00000000 0
R 13 0 003fffff 0
I 3c 0 0 0
R 3c 0 00000000 0
R 3d 0 002aaaaa 0
W 0e 12345678 0 0
R 0e 0 00145678 0
R 0f 0 00000000 0
